// ==== backend_consts.svh ====
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data and address width
`define XLEN 32

// dispatch lanes per cycle
`define FETCH_WIDTH 2

// one branch unit per dispatch lane
`define BRU_NUM 2

// reorder buffer depth, must be a power of two
`define ROB_SIZE 16

// fetch target queue depth
`define FTQ_SIZE 8

// instruction slot inside a fetch block
`define OFFSET_W 3

// derived index widths
`define ROB_IDX_W ($clog2(`ROB_SIZE))
`define FTQ_IDX_W ($clog2(`FTQ_SIZE))

`endif

// ==== backend_pkg.sv ====
`include "backend_consts.svh"

package backend_pkg;

    // wrap flag toggles each time the pointer passes the last entry
    typedef struct packed {
        logic                  flag;
        logic [`ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    typedef logic [`FTQ_IDX_W-1:0] ftq_idx_t;

    typedef enum logic [2:0] {
        bru_beq  = 3'd0,
        bru_bne  = 3'd1,
        bru_blt  = 3'd2,
        bru_bltu = 3'd3,
        bru_bge  = 3'd4,
        bru_jal  = 3'd5
    } bru_op_e;

    typedef enum logic [1:0] {
        rob_empty   = 2'd0,
        rob_waiting = 2'd1,
        rob_done    = 2'd2
    } rob_state_e;

    typedef struct packed {
        ftq_idx_t              ftq_idx;
        logic [`OFFSET_W-1:0]  offset;
        bru_op_e               op;
        logic [`XLEN-1:0]      src_a;
        logic [`XLEN-1:0]      src_b;
        logic [`XLEN-1:0]      br_offset;
        logic                  pred_taken;
        logic [`XLEN-1:0]      pred_target;
    } fetch_entry_t;

    typedef struct packed {
        rob_idx_t              rob_idx;
        ftq_idx_t              ftq_idx;
        logic [`OFFSET_W-1:0]  offset;
        logic                  taken;
        logic [`XLEN-1:0]      target;
        logic                  has_mispred;
    } branchwb_info_t;

    typedef struct packed {
        rob_idx_t              rob_idx;
        ftq_idx_t              ftq_idx;
        logic [`XLEN-1:0]      redirect_pc;
    } squash_info_t;

    // a is older than b
    function automatic logic rob_is_older(rob_idx_t a, rob_idx_t b);
        if (a.flag == b.flag) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

endpackage

// ==== oldest_select.sv ====
`timescale 1ns/10ps

module oldest_select #(
    parameter int WIDTH = 2
) (
    input  wire [WIDTH-1:0]             i_vld,
    input  backend_pkg::branchwb_info_t i_infos [WIDTH],
    output backend_pkg::branchwb_info_t o_oldest_info
);

    logic found;

    // linear scan, keeps the first valid entry until an older one shows up
    always_comb begin
        found = 1'b0;
        o_oldest_info = i_infos[0];
        for (int i = 0; i < WIDTH; i++) begin
            if (i_vld[i]) begin
                if (!found ||
                    backend_pkg::rob_is_older(i_infos[i].rob_idx, o_oldest_info.rob_idx)) begin
                    o_oldest_info = i_infos[i];
                end
                found = 1'b1;
            end
        end
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/10ps
`include "backend_consts.svh"

module branch_unit (
    input  wire                         clk,
    input  wire                         i_rst_n,

    input  wire                         i_issue_vld,
    input  backend_pkg::fetch_entry_t   i_inst,
    input  backend_pkg::rob_idx_t       i_rob_idx,

    // fetch block start address from the ftq read port
    input  wire [`XLEN-1:0]             i_start_addr,

    input  wire                         i_squash_vld,
    input  backend_pkg::squash_info_t   i_squash_info,

    output logic                        o_wb_vld,
    output backend_pkg::branchwb_info_t o_wb_info
);

    logic [`XLEN-1:0]            pc;
    logic [`XLEN-1:0]            seq_pc;
    logic [`XLEN-1:0]            jump_pc;
    logic                        taken;
    logic [`XLEN-1:0]            target;
    logic                        mispred;
    logic                        wb_vld_q;
    backend_pkg::branchwb_info_t wb_info_q;

    // instructions are 4 bytes apart inside the block
    assign pc = i_start_addr + {{(`XLEN - `OFFSET_W - 2){1'b0}}, i_inst.offset, 2'b00};
    assign seq_pc = pc + `XLEN'(4);
    assign jump_pc = pc + i_inst.br_offset;

    always_comb begin
        case (i_inst.op)
            backend_pkg::bru_beq:  taken = (i_inst.src_a == i_inst.src_b);
            backend_pkg::bru_bne:  taken = (i_inst.src_a != i_inst.src_b);
            backend_pkg::bru_blt:  taken = ($signed(i_inst.src_a) < $signed(i_inst.src_b));
            backend_pkg::bru_bltu: taken = (i_inst.src_a < i_inst.src_b);
            backend_pkg::bru_bge:  taken = ($signed(i_inst.src_a) >= $signed(i_inst.src_b));
            backend_pkg::bru_jal:  taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    assign target = taken ? jump_pc : seq_pc;

    // wrong direction, or right direction but wrong target
    assign mispred = (taken != i_inst.pred_taken) ||
                     (taken && (target != i_inst.pred_target));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wb_vld_q <= 1'b0;
        end else begin
            wb_vld_q <= i_issue_vld;
        end
    end

    always_ff @(posedge clk) begin
        wb_info_q.rob_idx     <= i_rob_idx;
        wb_info_q.ftq_idx     <= i_inst.ftq_idx;
        wb_info_q.offset      <= i_inst.offset;
        wb_info_q.taken       <= taken;
        wb_info_q.target      <= target;
        wb_info_q.has_mispred <= mispred;
    end

    // a squash in the writeback cycle kills anything younger than the branch
    assign o_wb_vld = wb_vld_q &&
                      !(i_squash_vld &&
                        backend_pkg::rob_is_older(i_squash_info.rob_idx, wb_info_q.rob_idx));
    assign o_wb_info = wb_info_q;

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/10ps
`include "backend_consts.svh"

module reorder_buffer (
    input  wire                       clk,
    input  wire                       i_rst_n,

    input  wire [`FETCH_WIDTH-1:0]    i_alloc_vld,
    input  backend_pkg::ftq_idx_t     i_alloc_ftq_idx [`FETCH_WIDTH],
    output backend_pkg::rob_idx_t     o_alloc_rob_idx [`FETCH_WIDTH],
    output logic                      o_stall,

    // completion from the branch units
    input  wire [`BRU_NUM-1:0]        i_wb_vld,
    input  backend_pkg::rob_idx_t     i_wb_rob_idx [`BRU_NUM],

    input  wire                       i_squash_vld,
    input  backend_pkg::squash_info_t i_squash_info,

    output logic                      o_commit_ftq_vld,
    output backend_pkg::ftq_idx_t     o_commit_ftq_idx
);

    backend_pkg::rob_state_e state_q [`ROB_SIZE];
    backend_pkg::ftq_idx_t   ftq_idx_q [`ROB_SIZE];
    backend_pkg::rob_idx_t   head_q;
    backend_pkg::rob_idx_t   tail_q;
    backend_pkg::rob_idx_t   squash_tail;

    logic [`ROB_IDX_W:0]     used_cnt;
    logic [`ROB_IDX_W:0]     free_cnt;
    logic [`ROB_IDX_W:0]     alloc_cnt;
    logic [`ROB_IDX_W-1:0]   squash_dist;
    logic [`ROB_SIZE-1:0]    squash_kill;
    logic                    commit_fire;

    // flag and index together count modulo twice the depth
    assign used_cnt = tail_q - head_q;
    assign free_cnt = (`ROB_IDX_W + 1)'(`ROB_SIZE) - used_cnt;
    assign o_stall = (free_cnt < `FETCH_WIDTH) || i_squash_vld;

    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            alloc_cnt = alloc_cnt + i_alloc_vld[i];
        end
    end

    // valid lanes are contiguous from lane 0
    generate
        for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : gen_alloc
            assign o_alloc_rob_idx[i] = tail_q + (`ROB_IDX_W + 1)'(i);
        end
    endgenerate

    // distance from head decides which slots are behind the branch
    assign squash_dist = i_squash_info.rob_idx.idx - head_q.idx;
    assign squash_tail = i_squash_info.rob_idx + 1'b1;

    always_comb begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
            squash_kill[i] = ((`ROB_IDX_W)'(i) - head_q.idx) > squash_dist;
        end
    end

    assign commit_fire = (state_q[head_q.idx] == backend_pkg::rob_done);
    assign o_commit_ftq_vld = commit_fire;
    assign o_commit_ftq_idx = ftq_idx_q[head_q.idx];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < `ROB_SIZE; i++) begin
                state_q[i] <= backend_pkg::rob_empty;
            end
        end else begin
            for (int i = 0; i < `BRU_NUM; i++) begin
                if (i_wb_vld[i]) begin
                    state_q[i_wb_rob_idx[i].idx] <= backend_pkg::rob_done;
                end
            end

            if (commit_fire) begin
                state_q[head_q.idx] <= backend_pkg::rob_empty;
                head_q <= head_q + 1'b1;
            end

            if (i_squash_vld) begin
                // the branch itself stays and commits later
                tail_q <= squash_tail;
                for (int i = 0; i < `ROB_SIZE; i++) begin
                    if (squash_kill[i]) begin
                        state_q[i] <= backend_pkg::rob_empty;
                    end
                end
            end else begin
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    if (i_alloc_vld[i]) begin
                        state_q[o_alloc_rob_idx[i].idx] <= backend_pkg::rob_waiting;
                    end
                end
                tail_q <= tail_q + alloc_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i_alloc_vld[i]) begin
                ftq_idx_q[o_alloc_rob_idx[i].idx] <= i_alloc_ftq_idx[i];
            end
        end
    end

endmodule

// ==== aura_backend.sv ====
`timescale 1ns/10ps
`include "backend_consts.svh"

module aura_backend (
    input  wire                         clk,
    input  wire                         i_rst_n,

    // from fetch
    output logic                        o_stall,
    input  wire [`FETCH_WIDTH-1:0]      i_inst_vld,
    input  backend_pkg::fetch_entry_t   i_inst [`FETCH_WIDTH],

    // ftq start address read, answered in the same cycle
    output backend_pkg::ftq_idx_t       o_read_ftq_idx [`BRU_NUM],
    input  wire [`XLEN-1:0]             i_read_ftq_start_addr [`BRU_NUM],

    // branch writeback to ftq
    output logic [`BRU_NUM-1:0]         o_branchwb_vld,
    output backend_pkg::branchwb_info_t o_branchwb_info [`BRU_NUM],

    output logic                        o_squash_vld,
    output backend_pkg::squash_info_t   o_squash_info,

    output logic                        o_commit_ftq_vld,
    output backend_pkg::ftq_idx_t       o_commit_ftq_idx
);

    logic [`FETCH_WIDTH-1:0]     issue_vld;
    backend_pkg::ftq_idx_t       alloc_ftq_idx [`FETCH_WIDTH];
    backend_pkg::rob_idx_t       alloc_rob_idx [`FETCH_WIDTH];

    logic [`BRU_NUM-1:0]         bru_wb_vld;
    backend_pkg::branchwb_info_t bru_wb_info [`BRU_NUM];
    backend_pkg::rob_idx_t       bru_wb_rob_idx [`BRU_NUM];
    logic [`BRU_NUM-1:0]         mispred_vld;
    backend_pkg::branchwb_info_t oldest_info;

    logic                        same_ftq_entry;
    logic                        lane0_older;

    logic                        squash_vld_q;
    backend_pkg::squash_info_t   squash_info_q;

    assign issue_vld = i_inst_vld & {`FETCH_WIDTH{~o_stall}};

    reorder_buffer u_reorder_buffer (
        .clk              ( clk              ),
        .i_rst_n          ( i_rst_n          ),
        .i_alloc_vld      ( issue_vld        ),
        .i_alloc_ftq_idx  ( alloc_ftq_idx    ),
        .o_alloc_rob_idx  ( alloc_rob_idx    ),
        .o_stall          ( o_stall          ),
        .i_wb_vld         ( bru_wb_vld       ),
        .i_wb_rob_idx     ( bru_wb_rob_idx   ),
        .i_squash_vld     ( squash_vld_q     ),
        .i_squash_info    ( squash_info_q    ),
        .o_commit_ftq_vld ( o_commit_ftq_vld ),
        .o_commit_ftq_idx ( o_commit_ftq_idx )
    );

    generate
        for (genvar i = 0; i < `BRU_NUM; i++) begin : gen_bru
            assign alloc_ftq_idx[i] = i_inst[i].ftq_idx;
            assign o_read_ftq_idx[i] = i_inst[i].ftq_idx;

            branch_unit u_branch_unit (
                .clk           ( clk                      ),
                .i_rst_n       ( i_rst_n                  ),
                .i_issue_vld   ( issue_vld[i]             ),
                .i_inst        ( i_inst[i]                ),
                .i_rob_idx     ( alloc_rob_idx[i]         ),
                .i_start_addr  ( i_read_ftq_start_addr[i] ),
                .i_squash_vld  ( squash_vld_q             ),
                .i_squash_info ( squash_info_q            ),
                .o_wb_vld      ( bru_wb_vld[i]            ),
                .o_wb_info     ( bru_wb_info[i]           )
            );

            assign bru_wb_rob_idx[i] = bru_wb_info[i].rob_idx;
            assign mispred_vld[i] = bru_wb_vld[i] && bru_wb_info[i].has_mispred;
            assign o_branchwb_info[i] = bru_wb_info[i];
        end
    endgenerate

    // two writebacks into one ftq entry, only the older lane updates it
    assign same_ftq_entry = (&bru_wb_vld) &&
                            (bru_wb_info[0].ftq_idx == bru_wb_info[1].ftq_idx);
    assign lane0_older = backend_pkg::rob_is_older(bru_wb_info[0].rob_idx,
                                                   bru_wb_info[1].rob_idx);
    assign o_branchwb_vld = same_ftq_entry ? (lane0_older ? 2'b01 : 2'b10) : bru_wb_vld;

    oldest_select #(
        .WIDTH ( `BRU_NUM )
    ) u_oldest_select (
        .i_vld         ( mispred_vld ),
        .i_infos       ( bru_wb_info ),
        .o_oldest_info ( oldest_info )
    );

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            squash_vld_q <= 1'b0;
        end else begin
            squash_vld_q <= |mispred_vld;
        end
    end

    // resolved target is the redirect pc for either direction
    always_ff @(posedge clk) begin
        if (|mispred_vld) begin
            squash_info_q.rob_idx     <= oldest_info.rob_idx;
            squash_info_q.ftq_idx     <= oldest_info.ftq_idx;
            squash_info_q.redirect_pc <= oldest_info.target;
        end
    end

    assign o_squash_vld = squash_vld_q;
    assign o_squash_info = squash_info_q;

endmodule

// ==== backend_properties.sv ====
`timescale 1ns/10ps
`include "backend_consts.svh"

module backend_properties (
    input wire                         clk,
    input wire                         i_rst_n,
    input wire                         o_stall,
    input wire [`BRU_NUM-1:0]          o_branchwb_vld,
    input backend_pkg::branchwb_info_t o_branchwb_info [`BRU_NUM],
    input wire                         o_squash_vld,
    input wire                         o_commit_ftq_vld
);

    // registers are back at reset values one edge after a reset edge
    reset_quiet: assert property (@(posedge clk)
        !i_rst_n |=> (!o_squash_vld && (o_branchwb_vld == '0) && !o_commit_ftq_vld && !o_stall))
        else $error("output strobe high after a reset cycle");

    squash_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_squash_vld |=> !o_squash_vld)
        else $error("squash valid held for two cycles");

    wb_ftq_filtered: assert property (@(posedge clk) disable iff (!i_rst_n)
        !((&o_branchwb_vld) && (o_branchwb_info[0].ftq_idx == o_branchwb_info[1].ftq_idx)))
        else $error("two branch writebacks to one ftq entry");

    // an instruction taken in during a stall would write back one cycle later
    no_issue_on_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_stall |=> (o_branchwb_vld == '0))
        else $error("dispatch accepted while stalled");

endmodule

bind aura_backend backend_properties u_backend_properties (
    .clk              ( clk              ),
    .i_rst_n          ( i_rst_n          ),
    .o_stall          ( o_stall          ),
    .o_branchwb_vld   ( o_branchwb_vld   ),
    .o_branchwb_info  ( o_branchwb_info  ),
    .o_squash_vld     ( o_squash_vld     ),
    .o_commit_ftq_vld ( o_commit_ftq_vld )
);

// ==== tb_aura_backend.sv ====
`timescale 1ns/10ps
`include "backend_consts.svh"

module tb_aura_backend;

    localparam int STIM_CYCLES = 400;
    // stimulus, then a full rob drained at up to 4 cycles per entry, plus margin
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + `ROB_SIZE * 4 + 136;
    // dual dispatch with correct predictions, long enough to fill the rob
    localparam int FILL_START = 200;
    localparam int FILL_CYCLES = 40;

    typedef struct packed {
        backend_pkg::rob_idx_t rob_idx;
        backend_pkg::ftq_idx_t ftq_idx;
        logic                  done;
    } rob_entry_t;

    logic                        clk;
    logic                        rst_n;
    logic                        stall;
    logic [`FETCH_WIDTH-1:0]     inst_vld;
    backend_pkg::fetch_entry_t   inst [`FETCH_WIDTH];
    backend_pkg::ftq_idx_t       read_ftq_idx [`BRU_NUM];
    logic [`XLEN-1:0]            read_ftq_start_addr [`BRU_NUM];
    logic [`BRU_NUM-1:0]         branchwb_vld;
    backend_pkg::branchwb_info_t branchwb_info [`BRU_NUM];
    logic                        squash_vld;
    backend_pkg::squash_info_t   squash_info;
    logic                        commit_ftq_vld;
    backend_pkg::ftq_idx_t       commit_ftq_idx;

    // ftq model, one start address per entry
    logic [`XLEN-1:0]            ftq_start [`FTQ_SIZE];

    // reference model state
    rob_entry_t                  rob_q [$];
    backend_pkg::rob_idx_t       tail_m;
    logic [`BRU_NUM-1:0]         pend_vld;
    backend_pkg::branchwb_info_t pend_info [`BRU_NUM];
    logic                        sq_vld_m;
    backend_pkg::squash_info_t   sq_info_m;

    int cycle_cnt;
    int n_squash;
    int n_filtered;
    int n_dual_mispred;
    int n_full;

    aura_backend i_aura_backend (
        .clk                   ( clk                 ),
        .i_rst_n               ( rst_n               ),
        .o_stall               ( stall               ),
        .i_inst_vld            ( inst_vld            ),
        .i_inst                ( inst                ),
        .o_read_ftq_idx        ( read_ftq_idx        ),
        .i_read_ftq_start_addr ( read_ftq_start_addr ),
        .o_branchwb_vld        ( branchwb_vld        ),
        .o_branchwb_info       ( branchwb_info       ),
        .o_squash_vld          ( squash_vld          ),
        .o_squash_info         ( squash_info         ),
        .o_commit_ftq_vld      ( commit_ftq_vld      ),
        .o_commit_ftq_idx      ( commit_ftq_idx      )
    );

    // ftq read ports answer in the same cycle
    generate
        for (genvar i = 0; i < `BRU_NUM; i++) begin : gen_ftq_read
            assign read_ftq_start_addr[i] = ftq_start[read_ftq_idx[i]];
        end
    endgenerate

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                fail_now("timeout, the rob did not drain within the cycle limit");
            end
        end
    end

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_strobe(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_branchwb(string name, backend_pkg::branchwb_info_t exp,
                                  backend_pkg::branchwb_info_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_squash(string name, backend_pkg::squash_info_t exp,
                                backend_pkg::squash_info_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_commit(string name, backend_pkg::ftq_idx_t exp,
                                backend_pkg::ftq_idx_t act);
        if (act !== exp) begin
            fail_now($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // same flag and smaller index, or different flag and larger index
    function automatic logic is_older(backend_pkg::rob_idx_t a, backend_pkg::rob_idx_t b);
        if (a.flag == b.flag) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    function automatic backend_pkg::rob_idx_t next_rob_idx(backend_pkg::rob_idx_t r, int n);
        logic [`ROB_IDX_W:0] sum;
        sum = r + (`ROB_IDX_W + 1)'(n);
        return backend_pkg::rob_idx_t'(sum);
    endfunction

    function automatic backend_pkg::branchwb_info_t resolve_branch(
        backend_pkg::fetch_entry_t e, logic [`XLEN-1:0] start, backend_pkg::rob_idx_t rob_idx);
        backend_pkg::branchwb_info_t r;
        logic [`XLEN-1:0]            pc;
        logic                        taken;
        pc = start + (`XLEN'(e.offset) << 2);
        case (e.op)
            backend_pkg::bru_beq:  taken = (e.src_a == e.src_b);
            backend_pkg::bru_bne:  taken = (e.src_a != e.src_b);
            backend_pkg::bru_blt:  taken = ($signed(e.src_a) < $signed(e.src_b));
            backend_pkg::bru_bltu: taken = (e.src_a < e.src_b);
            backend_pkg::bru_bge:  taken = ($signed(e.src_a) >= $signed(e.src_b));
            backend_pkg::bru_jal:  taken = 1'b1;
            default:               taken = 1'b0;
        endcase
        r.rob_idx = rob_idx;
        r.ftq_idx = e.ftq_idx;
        r.offset = e.offset;
        r.taken = taken;
        r.target = taken ? (pc + e.br_offset) : (pc + `XLEN'(4));
        r.has_mispred = (taken != e.pred_taken) || (taken && (r.target != e.pred_target));
        return r;
    endfunction

    task automatic drive_random(logic fill);
        int                          pick;
        backend_pkg::fetch_entry_t   e;
        backend_pkg::branchwb_info_t r;
        pick = $urandom_range(0, 3);
        if (fill) begin
            inst_vld = 2'b11;
        end else begin
            inst_vld = (pick == 0) ? 2'b00 : ((pick == 1) ? 2'b01 : 2'b11);
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            e = '0;
            e.ftq_idx = backend_pkg::ftq_idx_t'($urandom_range(0, `FTQ_SIZE - 1));
            // lane 1 shares lane 0's fetch block half the time
            if (i > 0 && $urandom_range(0, 1) == 1) begin
                e.ftq_idx = inst[0].ftq_idx;
            end
            e.offset = `OFFSET_W'($urandom_range(0, (1 << `OFFSET_W) - 1));
            e.op = backend_pkg::bru_op_e'($urandom_range(0, 5));
            e.src_a = $urandom;
            e.src_b = ($urandom_range(0, 2) == 0) ? e.src_a : $urandom;
            e.br_offset = `XLEN'($urandom_range(0, 255) * 4) - `XLEN'(512);
            r = resolve_branch(e, ftq_start[e.ftq_idx], '0);
            if (fill || $urandom_range(0, 1) == 1) begin
                e.pred_taken = r.taken;
                e.pred_target = r.target;
            end else begin
                e.pred_taken = 1'($urandom_range(0, 1));
                e.pred_target = $urandom & 32'hFFFF_FFFC;
            end
            inst[i] = e;
        end
    endtask

    // checks this cycle's outputs, then advances the model by one edge
    task automatic step_model();
        logic                        exp_stall;
        logic [`FETCH_WIDTH-1:0]     accepted;
        logic [`BRU_NUM-1:0]         raw_vld;
        logic [`BRU_NUM-1:0]         exp_wb_vld;
        logic                        exp_commit;
        backend_pkg::squash_info_t   next_sq_info;
        backend_pkg::branchwb_info_t oldest;
        backend_pkg::rob_idx_t       rob_idx;
        rob_entry_t                  ent;
        int                          n_mispred;

        exp_stall = ((`ROB_SIZE - rob_q.size()) < `FETCH_WIDTH) || sq_vld_m;
        if ((`ROB_SIZE - rob_q.size()) < `FETCH_WIDTH) begin
            n_full++;
        end
        check_strobe($sformatf("stall cycle %0d", cycle_cnt), exp_stall, stall);
        accepted = inst_vld & {`FETCH_WIDTH{~exp_stall}};

        for (int i = 0; i < `BRU_NUM; i++) begin
            raw_vld[i] = pend_vld[i] &&
                         !(sq_vld_m && is_older(sq_info_m.rob_idx, pend_info[i].rob_idx));
        end
        exp_wb_vld = raw_vld;
        if ((&raw_vld) && (pend_info[0].ftq_idx == pend_info[1].ftq_idx)) begin
            exp_wb_vld = is_older(pend_info[0].rob_idx, pend_info[1].rob_idx) ? 2'b01 : 2'b10;
            n_filtered++;
        end
        for (int i = 0; i < `BRU_NUM; i++) begin
            check_strobe($sformatf("branchwb_vld lane %0d cycle %0d", i, cycle_cnt),
                         exp_wb_vld[i], branchwb_vld[i]);
            if (raw_vld[i]) begin
                check_branchwb($sformatf("branchwb_info lane %0d cycle %0d", i, cycle_cnt),
                               pend_info[i], branchwb_info[i]);
            end
        end

        exp_commit = (rob_q.size() != 0) && rob_q[0].done;
        check_strobe($sformatf("commit_vld cycle %0d", cycle_cnt), exp_commit, commit_ftq_vld);
        if (exp_commit) begin
            check_commit($sformatf("commit_ftq_idx cycle %0d", cycle_cnt),
                         rob_q[0].ftq_idx, commit_ftq_idx);
        end

        check_strobe($sformatf("squash_vld cycle %0d", cycle_cnt), sq_vld_m, squash_vld);
        if (sq_vld_m) begin
            check_squash($sformatf("squash_info cycle %0d", cycle_cnt), sq_info_m, squash_info);
        end

        // oldest mispredicting writeback becomes next cycle's squash
        n_mispred = 0;
        oldest = pend_info[0];
        next_sq_info = sq_info_m;
        for (int i = 0; i < `BRU_NUM; i++) begin
            if (raw_vld[i] && pend_info[i].has_mispred) begin
                if (n_mispred == 0 || is_older(pend_info[i].rob_idx, oldest.rob_idx)) begin
                    oldest = pend_info[i];
                end
                n_mispred++;
            end
        end
        if (n_mispred > 1) begin
            n_dual_mispred++;
        end
        if (n_mispred > 0) begin
            next_sq_info.rob_idx = oldest.rob_idx;
            next_sq_info.ftq_idx = oldest.ftq_idx;
            next_sq_info.redirect_pc = oldest.target;
        end

        for (int i = 0; i < `BRU_NUM; i++) begin
            for (int k = 0; k < rob_q.size(); k++) begin
                if (raw_vld[i] && rob_q[k].rob_idx == pend_info[i].rob_idx) begin
                    rob_q[k].done = 1'b1;
                end
            end
        end
        if (exp_commit) begin
            void'(rob_q.pop_front());
        end

        // everything younger than the branch leaves the rob
        if (sq_vld_m) begin
            n_squash++;
            while (rob_q.size() != 0 && is_older(sq_info_m.rob_idx, rob_q[$].rob_idx)) begin
                void'(rob_q.pop_back());
            end
            tail_m = next_rob_idx(sq_info_m.rob_idx, 1);
        end

        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            pend_vld[i] = accepted[i];
            if (accepted[i]) begin
                rob_idx = next_rob_idx(tail_m, i);
                ent.rob_idx = rob_idx;
                ent.ftq_idx = inst[i].ftq_idx;
                ent.done = 1'b0;
                rob_q.push_back(ent);
                pend_info[i] = resolve_branch(inst[i], ftq_start[inst[i].ftq_idx], rob_idx);
            end
        end
        tail_m = next_rob_idx(tail_m, $countones(accepted));
        sq_vld_m = (n_mispred > 0);
        sq_info_m = next_sq_info;
    endtask

    task automatic run_cycle();
        @(negedge clk);
        step_model();
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(89696));
        rst_n = 1'b0;
        inst_vld = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            inst[i] = '0;
        end
        for (int i = 0; i < `FTQ_SIZE; i++) begin
            ftq_start[i] = $urandom & 32'hFFFF_FFF0;
        end
        n_squash = 0;
        n_filtered = 0;
        n_dual_mispred = 0;
        n_full = 0;
        rob_q.delete();
        tail_m = '0;
        pend_vld = '0;
        sq_vld_m = 1'b0;
        sq_info_m = '0;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int n = 0; n < STIM_CYCLES; n++) begin
            drive_random(n >= FILL_START && n < FILL_START + FILL_CYCLES);
            run_cycle();
        end

        // no more dispatch, let the rob drain
        inst_vld = '0;
        while (rob_q.size() != 0 || pend_vld != '0 || sq_vld_m) begin
            run_cycle();
        end
        repeat (4) run_cycle();

        if (n_squash == 0) begin
            fail_now("no squash happened during the run");
        end
        if (n_filtered == 0) begin
            fail_now("no writeback pair to the same ftq entry was seen");
        end
        if (n_dual_mispred == 0) begin
            fail_now("both lanes never mispredicted in the same cycle");
        end
        if (n_full == 0) begin
            fail_now("the rob never got close enough to full to stall");
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
backend_pkg.sv
oldest_select.sv
branch_unit.sv
reorder_buffer.sv
aura_backend.sv
backend_properties.sv
tb_aura_backend.sv
